/* hdl/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

	typedef logic [31:0] xlen_t;     // Data word, pc, immediates
	typedef logic [4:0]  reg_idx_t;  // Register index
	typedef logic [11:0] csr_addr_t;
	typedef logic [1:0]  priv_t;     // Privilege level

	localparam priv_t PRIV_U = 2'd0;
	localparam priv_t PRIV_S = 2'd1;
	localparam priv_t PRIV_M = 2'd3;

	// add x0,x0,x0
	localparam xlen_t NOP_INSTR = 32'h0000_0033;

	// RV32 major opcodes
	typedef enum logic [6:0] {
		LUI      = 7'b0110111,
		AUIPC    = 7'b0010111,
		JAL      = 7'b1101111,
		JALR     = 7'b1100111,
		BRANCH   = 7'b1100011,
		LOAD     = 7'b0000011,
		STORE    = 7'b0100011,
		OP_IMM   = 7'b0010011,
		OP       = 7'b0110011,
		MISC_MEM = 7'b0001111,
		SYSTEM   = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {FU_ALU = 3'd0, FU_MULDIV = 3'd1, FU_MEM = 3'd2,
		FU_CSR = 3'd3, FU_BRANCH = 3'd4} fu_e;

	// Numbered as {instr[30], funct3}
	typedef enum logic [3:0] {ADD = 4'd0, SLL = 4'd1, SLT = 4'd2, SLTU = 4'd3, XOR = 4'd4,
		SRL = 4'd5, OR = 4'd6, AND = 4'd7, SUB = 4'd8, SRA = 4'd13} alu_fn_e;

	// Loads 1 + funct3, stores 8 + funct3
	typedef enum logic [3:0] {NONE = 4'd0, LB = 4'd1, LH = 4'd2, LW = 4'd3, LBU = 4'd5,
		LHU = 4'd6, SB = 4'd8, SH = 4'd9, SW = 4'd10} mem_op_e;

	// 8 + funct3 for the M extension
	typedef enum logic [3:0] {MD_NONE = 4'd0, MUL = 4'd8, MULH = 4'd9, MULHSU = 4'd10,
		MULHU = 4'd11, DIV = 4'd12, DIVU = 4'd13, REM = 4'd14, REMU = 4'd15} muldiv_op_e;

	typedef enum logic [1:0] {PC_PLUS4 = 2'd0, PC_BRANCH = 2'd1, PC_JAL = 2'd2,
		PC_JALR = 2'd3} pcsel_e;

	typedef enum logic [1:0] {B_REG = 2'd0, B_IMM = 2'd1, B_PC4 = 2'd2} bsel_e;

endpackage

`default_nettype wire

/* hdl/instr_fields_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Latched instruction split into its fields
interface instr_fields_if;

	rv_decode_pkg::opcode_e  opcode;
	logic [2:0]              funct3;
	logic [6:0]              funct7;
	logic [11:0]             funct12;  // Also the CSR address
	rv_decode_pkg::reg_idx_t rd;
	rv_decode_pkg::reg_idx_t rs1;
	rv_decode_pkg::reg_idx_t rs2;
	rv_decode_pkg::xlen_t    instr;    // Whole word for immediates

	// Stage register side
	modport source (
		output opcode, funct3, funct7, funct12, rd, rs1, rs2, instr
	);

	// Immediate generator rebuilds from raw bits
	modport imm (
		input instr
	);

	// Control decoder
	modport dec (
		input opcode, funct3, funct7, funct12, rd
	);

endinterface

`default_nettype wire

/* hdl/stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
	parameter rv_decode_pkg::xlen_t reset_pc = '0
) (
	input  wire logic                 clk,
	input  wire logic                 nrst,
	input  wire rv_decode_pkg::xlen_t pc_in,
	input  wire rv_decode_pkg::xlen_t instr_in,
	input  wire logic                 misaligned_in,
	input  wire logic                 stall,
	input  wire logic                 nostall,
	input  wire logic                 discard,
	input  wire logic                 stall_mem,
	input  wire logic                 arb_eqmem,
	input  wire logic                 memop_done,
	output rv_decode_pkg::xlen_t      pc,
	output logic                      misaligned,
	instr_fields_if.source            fields
);

	rv_decode_pkg::xlen_t instr_q;
	logic                 flush;
	logic                 mem_hold;

	assign flush    = (stall && nostall) || discard;      // Scoreboard kill or branch discard
	assign mem_hold = stall_mem || (arb_eqmem && !memop_done);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			instr_q    <= rv_decode_pkg::NOP_INSTR;
			pc         <= reset_pc;
			misaligned <= 1'b0;
		end
		else if (flush)
		begin
			instr_q <= rv_decode_pkg::NOP_INSTR;  // pc and misaligned keep their value
		end
		else if (!mem_hold)
		begin
			instr_q    <= instr_in;
			pc         <= pc_in;
			misaligned <= misaligned_in;
		end
	end

	// Field split
	assign fields.instr   = instr_q;
	assign fields.opcode  = rv_decode_pkg::opcode_e'(instr_q[6:0]);
	assign fields.rd      = instr_q[11:7];
	assign fields.funct3  = instr_q[14:12];
	assign fields.rs1     = instr_q[19:15];
	assign fields.rs2     = instr_q[24:20];
	assign fields.funct7  = instr_q[31:25];
	assign fields.funct12 = instr_q[31:20];

	// Flush wins even over a pending memory hold
	a_flush_nop: assert property (@(posedge clk) disable iff (!nrst)
		flush |=> instr_q == rv_decode_pkg::NOP_INSTR)
		else $error("stage_reg: flush did not load NOP");

endmodule

`default_nettype wire

/* hdl/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
	instr_fields_if.imm             fields,
	output rv_decode_pkg::xlen_t    i_imm,
	output rv_decode_pkg::xlen_t    s_imm,
	output rv_decode_pkg::xlen_t    b_imm,
	output rv_decode_pkg::xlen_t    u_imm,
	output rv_decode_pkg::xlen_t    j_imm,
	output rv_decode_pkg::reg_idx_t shamt,
	output rv_decode_pkg::xlen_t    csr_imm
);

	rv_decode_pkg::xlen_t ins;
	logic                 sgn;

	assign ins = fields.instr;
	assign sgn = ins[31];  // Every signed format takes its sign from bit 31

	// Loads, OP_IMM, JALR
	assign i_imm = {{20{sgn}}, ins[31:20]};

	// Stores split around rd
	assign s_imm = {{20{sgn}}, ins[31:25], ins[11:7]};

	// Branch offset, bit 0 always zero
	assign b_imm = {{19{sgn}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};

	assign u_imm = {ins[31:12], 12'h000};  // LUI / AUIPC

	// JAL offset
	assign j_imm = {{11{sgn}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

	assign shamt = ins[24:20];

	// CSRRxI immediate sits in the rs1 field
	assign csr_imm = {27'd0, ins[19:15]};

endmodule

`default_nettype wire

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	instr_fields_if.dec               fields,
	input  wire logic                 exception_pending,
	input  wire logic                 illegal_flag,
	input  wire logic                 tsr,
	input  wire rv_decode_pkg::priv_t current_mode,
	output rv_decode_pkg::pcsel_e     pcselect,
	output logic                      we,
	output rv_decode_pkg::bsel_e      b_sel,
	output rv_decode_pkg::alu_fn_e    alu_fn,
	output rv_decode_pkg::fu_e        fn,
	output logic                      bneq,
	output logic                      btype,
	output logic                      j,
	output logic                      jr,
	output logic                      lui,
	output logic                      auipc,
	output rv_decode_pkg::mem_op_e    mem_op,
	output rv_decode_pkg::muldiv_op_e muldiv_op,
	output logic                      ecall,
	output logic                      ebreak,
	output logic                      mret,
	output logic                      sret,
	output logic                      uret,
	output logic                      illegal_instr,
	output logic                      csr_we
);

	logic                   we_raw;       // Before rd and kill gating
	logic                   csr_raw;
	logic                   illegal_raw;
	rv_decode_pkg::mem_op_e mem_raw;
	logic                   kill;
	logic [2:0]             f3;
	logic [6:0]             f7;

	assign f3 = fields.funct3;
	assign f7 = fields.funct7;

	always_comb
	begin
		pcselect    = rv_decode_pkg::PC_PLUS4;
		we_raw      = 1'b0;
		b_sel       = rv_decode_pkg::B_REG;
		alu_fn      = rv_decode_pkg::ADD;
		fn          = rv_decode_pkg::FU_ALU;
		bneq        = 1'b0;
		btype       = 1'b0;
		j           = 1'b0;
		jr          = 1'b0;
		lui         = 1'b0;
		auipc       = 1'b0;
		mem_raw     = rv_decode_pkg::NONE;
		muldiv_op   = rv_decode_pkg::MD_NONE;
		ecall       = 1'b0;
		ebreak      = 1'b0;
		mret        = 1'b0;
		sret        = 1'b0;
		uret        = 1'b0;
		csr_raw     = 1'b0;
		illegal_raw = 1'b0;

		case (fields.opcode)
			rv_decode_pkg::LUI:
			begin
				we_raw = 1'b1;
				b_sel  = rv_decode_pkg::B_IMM;
				lui    = 1'b1;
			end
			rv_decode_pkg::AUIPC:
			begin
				we_raw = 1'b1;
				b_sel  = rv_decode_pkg::B_IMM;
				auipc  = 1'b1;
			end
			rv_decode_pkg::JAL:
			begin
				we_raw   = 1'b1;
				fn       = rv_decode_pkg::FU_BRANCH;
				b_sel    = rv_decode_pkg::B_PC4;  // Link value pc+4
				pcselect = rv_decode_pkg::PC_JAL;
				j        = 1'b1;
			end
			rv_decode_pkg::JALR:
			begin
				we_raw      = 1'b1;
				fn          = rv_decode_pkg::FU_BRANCH;
				b_sel       = rv_decode_pkg::B_PC4;
				pcselect    = rv_decode_pkg::PC_JALR;
				jr          = 1'b1;
				illegal_raw = (f3 != 3'd0);
			end
			rv_decode_pkg::BRANCH:
			begin
				fn          = rv_decode_pkg::FU_BRANCH;
				pcselect    = rv_decode_pkg::PC_BRANCH;
				btype       = 1'b1;
				bneq        = f3[0];            // Inverts the compare result
				illegal_raw = (f3[2:1] == 2'b01);  // funct3 2 and 3 unused
				// Compare op: equality, signed or unsigned less than
				if (!f3[2])
					alu_fn = rv_decode_pkg::SUB;
				else if (!f3[1])
					alu_fn = rv_decode_pkg::SLT;
				else
					alu_fn = rv_decode_pkg::SLTU;
			end
			rv_decode_pkg::LOAD:
			begin
				we_raw      = 1'b1;
				fn          = rv_decode_pkg::FU_MEM;
				b_sel       = rv_decode_pkg::B_IMM;
				mem_raw     = rv_decode_pkg::mem_op_e'({1'b0, f3} + 4'd1);
				illegal_raw = (f3 == 3'd3) || (f3 > 3'd5);
			end
			rv_decode_pkg::STORE:
			begin
				fn          = rv_decode_pkg::FU_MEM;
				b_sel       = rv_decode_pkg::B_IMM;
				mem_raw     = rv_decode_pkg::mem_op_e'({1'b1, f3});  // 8 + funct3
				illegal_raw = (f3 > 3'd2);
			end
			rv_decode_pkg::OP_IMM:
			begin
				we_raw = 1'b1;
				b_sel  = rv_decode_pkg::B_IMM;
				if (f3 == 3'd1)                 // SLLI
				begin
					alu_fn      = rv_decode_pkg::SLL;
					illegal_raw = (f7 != 7'h00);
				end
				else if (f3 == 3'd5)            // SRLI / SRAI
				begin
					alu_fn      = rv_decode_pkg::alu_fn_e'({f7[5], f3});
					illegal_raw = (f7 != 7'h00) && (f7 != 7'h20);
				end
				else
					alu_fn = rv_decode_pkg::alu_fn_e'({1'b0, f3});  // No SUBI
			end
			rv_decode_pkg::OP:
			begin
				we_raw = 1'b1;
				if (f7 == 7'h01)
				begin
					fn        = rv_decode_pkg::FU_MULDIV;
					muldiv_op = rv_decode_pkg::muldiv_op_e'({1'b1, f3});
				end
				else if (f7 == 7'h00)
					alu_fn = rv_decode_pkg::alu_fn_e'({1'b0, f3});
				else if ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)))
					alu_fn = rv_decode_pkg::alu_fn_e'({1'b1, f3});  // SUB, SRA
				else
					illegal_raw = 1'b1;
			end
			rv_decode_pkg::MISC_MEM:
			begin
				// FENCE retires as a NOP
			end
			rv_decode_pkg::SYSTEM:
			begin
				if (f3 == 3'd0)
				begin
					case (fields.funct12)
						12'h000: ecall  = 1'b1;
						12'h001: ebreak = 1'b1;
						12'h002: uret   = 1'b1;
						12'h102:
						begin
							// Trapped from U, or from S when TSR set
							if ((current_mode == rv_decode_pkg::PRIV_U) ||
								((current_mode == rv_decode_pkg::PRIV_S) && tsr))
								illegal_raw = 1'b1;
							else
								sret = 1'b1;
						end
						12'h302:
						begin
							if (current_mode != rv_decode_pkg::PRIV_M)
								illegal_raw = 1'b1;
							else
								mret = 1'b1;
						end
						default: illegal_raw = 1'b1;
					endcase
				end
				else if (f3 == 3'd4)
					illegal_raw = 1'b1;  // Reserved funct3
				else
				begin
					we_raw  = 1'b1;      // Old CSR value to rd
					fn      = rv_decode_pkg::FU_CSR;
					csr_raw = 1'b1;
				end
			end
			default: illegal_raw = 1'b1;
		endcase
	end

	assign illegal_instr = illegal_raw || illegal_flag;
	assign kill          = illegal_instr || exception_pending;  // No side effects past here

	assign we     = we_raw && (fields.rd != 5'd0) && !kill;
	assign csr_we = csr_raw && !kill;
	assign mem_op = kill ? rv_decode_pkg::NONE : mem_raw;

	// Issue picks one jump target source
	always_comb
	begin
		a_one_jump: assert (!(j && jr))
			else $error("instr_decoder: j and jr both set");
	end

endmodule

`default_nettype wire

/* hdl/instdec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module instdec_stage #(
	parameter rv_decode_pkg::xlen_t reset_pc = '0  // pc after reset
) (
	input  wire logic                 clk,
	input  wire logic                 nrst,
	input  wire rv_decode_pkg::xlen_t pc_in,
	input  wire rv_decode_pkg::xlen_t instr_in,
	input  wire logic                 misaligned_in,
	input  wire logic                 exception_pending,
	input  wire logic                 illegal_flag,
	input  wire logic                 tsr,
	input  wire rv_decode_pkg::priv_t current_mode,
	input  wire logic                 stall,
	input  wire logic                 nostall,
	input  wire logic                 discard,
	input  wire logic                 stall_mem,
	input  wire logic                 arb_eqmem,
	input  wire logic                 memop_done,
	output rv_decode_pkg::reg_idx_t   rs1,
	output rv_decode_pkg::reg_idx_t   rs2,
	output rv_decode_pkg::reg_idx_t   rd,
	output rv_decode_pkg::xlen_t      i_imm,
	output rv_decode_pkg::xlen_t      s_imm,
	output rv_decode_pkg::xlen_t      b_imm,
	output rv_decode_pkg::xlen_t      u_imm,
	output rv_decode_pkg::xlen_t      j_imm,
	output rv_decode_pkg::reg_idx_t   shamt,
	output rv_decode_pkg::xlen_t      csr_imm,
	output rv_decode_pkg::xlen_t      pc,
	output logic [6:0]                opcode,
	output logic [2:0]                funct3,
	output rv_decode_pkg::csr_addr_t  csr_addr,
	output logic                      instruction_addr_misaligned,
	output rv_decode_pkg::pcsel_e     pcselect,
	output logic                      we,
	output rv_decode_pkg::bsel_e      b_sel,
	output rv_decode_pkg::alu_fn_e    alu_fn,
	output rv_decode_pkg::fu_e        fn,
	output logic                      bneq,
	output logic                      btype,
	output logic                      j,
	output logic                      jr,
	output logic                      lui,
	output logic                      auipc,
	output rv_decode_pkg::mem_op_e    mem_op,
	output rv_decode_pkg::muldiv_op_e muldiv_op,
	output logic                      ecall,
	output logic                      ebreak,
	output logic                      mret,
	output logic                      sret,
	output logic                      uret,
	output logic                      illegal_instr,
	output logic                      csr_we
);

	instr_fields_if fields ();

	stage_reg #(.reset_pc(reset_pc)) u_stage_reg (
		.clk, .nrst, .pc_in, .instr_in, .misaligned_in,
		.stall, .nostall, .discard, .stall_mem, .arb_eqmem, .memop_done,
		.pc, .misaligned(instruction_addr_misaligned), .fields(fields.source)
	);

	imm_gen u_imm_gen (
		.fields(fields.imm), .i_imm, .s_imm, .b_imm, .u_imm, .j_imm, .shamt, .csr_imm
	);

	instr_decoder u_instr_decoder (
		.fields(fields.dec), .exception_pending, .illegal_flag, .tsr, .current_mode,
		.pcselect, .we, .b_sel, .alu_fn, .fn, .bneq, .btype, .j, .jr, .lui, .auipc,
		.mem_op, .muldiv_op, .ecall, .ebreak, .mret, .sret, .uret, .illegal_instr, .csr_we
	);

	// Operand fields to issue, CSR fields to the CSR unit
	assign rs1      = fields.rs1;
	assign rs2      = fields.rs2;
	assign rd       = fields.rd;
	assign opcode   = fields.opcode;
	assign funct3   = fields.funct3;
	assign csr_addr = fields.funct12;  // Same bits as funct12

endmodule

`default_nettype wire

/* sim/tb_instdec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_instdec_stage;

	localparam int NUM_TESTS   = 35;
	localparam int WATCHDOG_NS = (NUM_TESTS + 20) * 4;  // One table row per cycle plus margin
	localparam logic [31:0] NOP = 32'h0000_0033;     // add x0,x0,x0

	// Pipeline controls {stall, nostall, discard, stall_mem, arb_eqmem, memop_done}
	localparam logic [5:0] RUN  = 6'b000_000;
	localparam logic [5:0] KILL = 6'b110_000;  // Scoreboard flush
	localparam logic [5:0] DISC = 6'b001_000;
	localparam logic [5:0] HMEM = 6'b000_100;
	localparam logic [5:0] HARB = 6'b000_010;  // Arbiter busy with op not done
	localparam logic [5:0] ARBD = 6'b000_011;  // Arbiter busy but op done so no hold
	localparam logic [5:0] STL  = 6'b100_000;  // Stall alone is no flush
	localparam logic [5:0] DHM  = 6'b001_100;  // Flush beats hold

	// Side inputs {illegal_flag, exception_pending, tsr, current_mode}
	localparam logic [4:0] SM = 5'b000_11;
	localparam logic [4:0] SS = 5'b000_01;
	localparam logic [4:0] ST = 5'b001_01;  // S mode with TSR
	localparam logic [4:0] SU = 5'b000_00;
	localparam logic [4:0] SX = 5'b010_11;  // Exception pending
	localparam logic [4:0] SI = 5'b100_11;  // Fetch marked illegal

	// Immediate to compare
	localparam int IMM_NONE = 0;
	localparam int IMM_I    = 1;
	localparam int IMM_S    = 2;
	localparam int IMM_B    = 3;
	localparam int IMM_U    = 4;
	localparam int IMM_J    = 5;
	localparam int IMM_CSR  = 6;

	typedef struct packed {
		logic [31:0] instr;
		logic [5:0]  ctl;
		logic [4:0]  side;
		logic        we;
		logic [2:0]  fn;
		logic [3:0]  alu;
		logic [1:0]  bsel;
		logic [3:0]  mem;
		logic [3:0]  md;
		logic [1:0]  pcs;
		logic        ill;
		logic [2:0]  kind;
		// {ecall, ebreak, mret, sret, csr_we, bneq, j, jr, btype, lui, auipc, uret}
		logic [11:0] flags;
	} vec_t;

	logic        clk = 1'b0;
	logic        nrst;
	logic [31:0] pc_in, instr_in;
	logic        misaligned_in, exception_pending, illegal_flag, tsr;
	logic [1:0]  current_mode;
	logic        stall, nostall, discard, stall_mem, arb_eqmem, memop_done;

	logic [4:0]  rs1, rs2, rd, shamt;
	logic [31:0] i_imm, s_imm, b_imm, u_imm, j_imm, csr_imm, pc;
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [11:0] csr_addr;
	logic        instruction_addr_misaligned;
	logic [1:0]  pcselect, b_sel;
	logic [3:0]  alu_fn, mem_op, muldiv_op;
	logic [2:0]  fn;
	logic        we, bneq, btype, j, jr, lui, auipc;
	logic        ecall, ebreak, mret, sret, uret, illegal_instr, csr_we;

	vec_t        tests [NUM_TESTS];
	logic [31:0] pcs [NUM_TESTS];
	logic        mis [NUM_TESTS];
	int          n_rows;
	int          errors;
	int          checks;
	logic [31:0] exp_instr;  // Model of the stage register
	logic [31:0] exp_pc;
	logic        exp_mis;

	instdec_stage u_instdec_stage (.*);

	initial
	begin
		forever #2 clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout: the test table did not finish in %0d ns", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic add(input logic [31:0] instr, input logic [5:0] ctl, input logic [4:0] side,
		input int we_e, input int fn_e, input int alu_e, input int bsel_e, input int mem_e,
		input int md_e, input int pcs_e, input int ill_e, input int kind_e,
		input logic [11:0] flags);
		vec_t v;
		v.instr = instr;
		v.ctl   = ctl;
		v.side  = side;
		v.we    = we_e[0];
		v.fn    = fn_e[2:0];
		v.alu   = alu_e[3:0];
		v.bsel  = bsel_e[1:0];
		v.mem   = mem_e[3:0];
		v.md    = md_e[3:0];
		v.pcs   = pcs_e[1:0];
		v.ill   = ill_e[0];
		v.kind  = kind_e[2:0];
		v.flags = flags;
		tests[n_rows] = v;
		n_rows++;
	endtask

	// Columns are instr, ctl, side, we, fn, alu_fn, b_sel, mem_op, muldiv_op, pcsel,
	// illegal, imm and flags
	task automatic load_table();
		n_rows = 0;
		add(32'hFFD30293, RUN,  SM, 1, 0,  0, 1, 0,  0, 0, 0, IMM_I,    12'h000); // ADDI x5,x6,-3
		add(32'h409403B3, RUN,  SM, 1, 0,  8, 0, 0,  0, 0, 0, IMM_NONE, 12'h000); // SUB
		add(32'h40C5D533, RUN,  SM, 1, 0, 13, 0, 0,  0, 0, 0, IMM_NONE, 12'h000); // SRA
		add(32'hABCDE0B7, RUN,  SM, 1, 0,  0, 1, 0,  0, 0, 0, IMM_U,    12'h004); // LUI
		add(32'h80001117, RUN,  SM, 1, 0,  0, 1, 0,  0, 0, 0, IMM_U,    12'h002); // AUIPC
		add(32'hFF822183, RUN,  SM, 1, 2,  0, 1, 3,  0, 0, 0, IMM_I,    12'h000); // LW x3,-8(x4)
		add(32'hF8530E23, RUN,  SM, 0, 2,  0, 1, 8,  0, 0, 0, IMM_S,    12'h000); // SB offset -100
		add(32'hFE2090E3, RUN,  SM, 0, 4,  8, 0, 0,  0, 1, 0, IMM_B,    12'h048); // BNE -32
		add(32'hFFDFF0EF, RUN,  SM, 1, 4,  0, 2, 0,  0, 2, 0, IMM_J,    12'h020); // JAL ra,-4
		add(32'h00008067, RUN,  SM, 0, 4,  0, 2, 0,  0, 3, 0, IMM_I,    12'h010); // ret with rd x0
		add(32'h02F706B3, RUN,  SM, 1, 1,  0, 0, 0,  8, 0, 0, IMM_NONE, 12'h000); // MUL
		add(32'h0328D833, RUN,  SM, 1, 1,  0, 0, 0, 13, 0, 0, IMM_NONE, 12'h000); // DIVU
		add(32'hFFD30293, KILL, SM, 0, 0,  0, 0, 0,  0, 0, 0, IMM_NONE, 12'h000); // Flushed to NOP
		add(32'hFF822183, DISC, SM, 0, 0,  0, 0, 0,  0, 0, 0, IMM_NONE, 12'h000);
		add(32'h409403B3, RUN,  SM, 1, 0,  8, 0, 0,  0, 0, 0, IMM_NONE, 12'h000);
		add(32'hFFD30293, HMEM, SM, 1, 0,  8, 0, 0,  0, 0, 0, IMM_NONE, 12'h000); // SUB held
		add(32'hFFD30293, HARB, SM, 1, 0,  8, 0, 0,  0, 0, 0, IMM_NONE, 12'h000);
		add(32'hFFD30293, ARBD, SM, 1, 0,  0, 1, 0,  0, 0, 0, IMM_I,    12'h000);
		add(32'hFF822183, DHM,  SM, 0, 0,  0, 0, 0,  0, 0, 0, IMM_NONE, 12'h000);
		add(32'hABCDE0B7, STL,  SM, 1, 0,  0, 1, 0,  0, 0, 0, IMM_U,    12'h004);
		add(32'h30200073, RUN,  SS, 0, 0,  0, 0, 0,  0, 0, 1, IMM_NONE, 12'h000); // MRET in S
		add(32'h30200073, RUN,  SM, 0, 0,  0, 0, 0,  0, 0, 0, IMM_NONE, 12'h200);
		add(32'h10200073, RUN,  ST, 0, 0,  0, 0, 0,  0, 0, 1, IMM_NONE, 12'h000); // SRET trapped
		add(32'h10200073, RUN,  SM, 0, 0,  0, 0, 0,  0, 0, 0, IMM_NONE, 12'h100);
		add(32'h10200073, RUN,  SS, 0, 0,  0, 0, 0,  0, 0, 0, IMM_NONE, 12'h100);
		add(32'h10200073, RUN,  SU, 0, 0,  0, 0, 0,  0, 0, 1, IMM_NONE, 12'h000);
		add(32'h0000007B, RUN,  SM, 0, 0,  0, 0, 0,  0, 0, 1, IMM_NONE, 12'h000); // Bad opcode
		add(32'hFFD30293, RUN,  SI, 0, 0,  0, 1, 0,  0, 0, 1, IMM_I,    12'h000);
		add(32'h00000073, RUN,  SM, 0, 0,  0, 0, 0,  0, 0, 0, IMM_NONE, 12'h800); // ECALL
		add(32'h00100073, RUN,  SM, 0, 0,  0, 0, 0,  0, 0, 0, IMM_NONE, 12'h400); // EBREAK
		add(32'h00200073, RUN,  SM, 0, 0,  0, 0, 0,  0, 0, 0, IMM_NONE, 12'h001); // URET
		add(32'hFF822183, RUN,  SX, 0, 2,  0, 1, 0,  0, 0, 0, IMM_I,    12'h000); // LW killed
		add(32'h30531273, RUN,  SM, 1, 3,  0, 0, 0,  0, 0, 0, IMM_CSR,  12'h080); // CSRRW 0x305
		add(32'h30531273, RUN,  SX, 0, 3,  0, 0, 0,  0, 0, 0, IMM_CSR,  12'h000);
		add(32'h0FF0000F, RUN,  SM, 0, 0,  0, 0, 0,  0, 0, 0, IMM_NONE, 12'h000); // FENCE
	endtask

	// RISC-V immediate formats
	function automatic logic [31:0] rebuild_imm(input logic [2:0] kind, input logic [31:0] w);
		case (kind)
			IMM_I:   return {{20{w[31]}}, w[31:20]};
			IMM_S:   return {{20{w[31]}}, w[31:25], w[11:7]};
			IMM_B:   return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			IMM_U:   return {w[31:12], 12'h000};
			IMM_J:   return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			IMM_CSR: return {27'd0, w[19:15]};
			default: return 32'h0;
		endcase
	endfunction

	task automatic expect_eq(input int idx, input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t: row %0d %s is %h, expected %h", $time, idx, what, got, exp);
		end
	endtask

	task automatic drive_regs(input int idx);
		if (idx < NUM_TESTS)
		begin
			instr_in      <= tests[idx].instr;
			pc_in         <= pcs[idx];
			misaligned_in <= mis[idx];
			{stall, nostall, discard, stall_mem, arb_eqmem, memop_done} <= tests[idx].ctl;
		end
		else
		begin
			instr_in <= NOP;  // Idle after the last row
			{stall, nostall, discard, stall_mem, arb_eqmem, memop_done} <= RUN;
		end
	endtask

	// Decode side inputs bypass the register and so lag a cycle
	task automatic drive_side(input int idx);
		{illegal_flag, exception_pending, tsr, current_mode} <= tests[idx].side;
	endtask

	task automatic check_reset();
		expect_eq(-1, "pc", pc, 32'h0);
		expect_eq(-1, "misaligned", 32'(instruction_addr_misaligned), 32'h0);
		expect_eq(-1, "rd", 32'(rd), 32'h0);
		expect_eq(-1, "control flags", 32'({we, csr_we, btype, j, jr, lui, auipc, bneq,
			ecall, ebreak, mret, sret, uret, illegal_instr}), 32'h0);
		expect_eq(-1, "mem/muldiv/pcselect", 32'({mem_op, muldiv_op, pcselect}), 32'h0);
	endtask

	task automatic check_entry(input int idx);
		vec_t        v;
		logic [31:0] got_imm;
		v = tests[idx];
		// Stage register model with flush before hold before load
		if ((v.ctl[5] && v.ctl[4]) || v.ctl[3])
			exp_instr = NOP;
		else if (!(v.ctl[2] || (v.ctl[1] && !v.ctl[0])))
		begin
			exp_instr = v.instr;
			exp_pc    = pcs[idx];
			exp_mis   = mis[idx];
		end
		expect_eq(idx, "pc", pc, exp_pc);
		expect_eq(idx, "misaligned", 32'(instruction_addr_misaligned), 32'(exp_mis));
		expect_eq(idx, "rs1", 32'(rs1), 32'(exp_instr[19:15]));
		expect_eq(idx, "rs2", 32'(rs2), 32'(exp_instr[24:20]));
		expect_eq(idx, "rd", 32'(rd), 32'(exp_instr[11:7]));
		expect_eq(idx, "shamt", 32'(shamt), 32'(exp_instr[24:20]));
		expect_eq(idx, "opcode", 32'(opcode), 32'(exp_instr[6:0]));
		expect_eq(idx, "funct3", 32'(funct3), 32'(exp_instr[14:12]));
		expect_eq(idx, "csr_addr", 32'(csr_addr), 32'(exp_instr[31:20]));
		expect_eq(idx, "we", 32'(we), 32'(v.we));
		expect_eq(idx, "fn", 32'(fn), 32'(v.fn));
		expect_eq(idx, "alu_fn", 32'(alu_fn), 32'(v.alu));
		expect_eq(idx, "b_sel", 32'(b_sel), 32'(v.bsel));
		expect_eq(idx, "mem_op", 32'(mem_op), 32'(v.mem));
		expect_eq(idx, "muldiv_op", 32'(muldiv_op), 32'(v.md));
		expect_eq(idx, "pcselect", 32'(pcselect), 32'(v.pcs));
		expect_eq(idx, "illegal_instr", 32'(illegal_instr), 32'(v.ill));
		expect_eq(idx, "flags", 32'({ecall, ebreak, mret, sret, csr_we, bneq, j, jr,
			btype, lui, auipc, uret}), 32'(v.flags));
		case (v.kind)
			IMM_I:   got_imm = i_imm;
			IMM_S:   got_imm = s_imm;
			IMM_B:   got_imm = b_imm;
			IMM_U:   got_imm = u_imm;
			IMM_J:   got_imm = j_imm;
			IMM_CSR: got_imm = csr_imm;
			default: got_imm = 32'h0;
		endcase
		if (v.kind != IMM_NONE)
			expect_eq(idx, "immediate", got_imm, rebuild_imm(v.kind, exp_instr));
	endtask

	initial
	begin
		logic [31:0] rnd;
		errors            = 0;
		checks            = 0;
		nrst              = 1'b0;
		instr_in          = NOP;
		pc_in             = 32'h0;
		misaligned_in     = 1'b0;
		exception_pending = 1'b0;
		illegal_flag      = 1'b0;
		tsr               = 1'b0;
		current_mode      = 2'd3;
		{stall, nostall, discard, stall_mem, arb_eqmem, memop_done} = RUN;
		void'($urandom(19226));
		load_table();
		for (int i = 0; i < NUM_TESTS; i++)
		begin
			rnd    = $urandom;
			pcs[i] = rnd;
			rnd    = $urandom;
			mis[i] = rnd[0];
		end
		exp_instr = NOP;  // Reset contents
		exp_pc    = 32'h0;
		exp_mis   = 1'b0;

		repeat (5) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		check_reset();

		// Row i goes in on this edge while row i-1 is latched and checked
		for (int i = 0; i <= NUM_TESTS; i++)
		begin
			@(posedge clk);
			drive_regs(i);
			if (i > 0)
				drive_side(i - 1);
			@(negedge clk);
			if (i > 0)
				check_entry(i - 1);
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
hdl/rv_decode_pkg.sv
hdl/instr_fields_if.sv
hdl/stage_reg.sv
hdl/imm_gen.sv
hdl/instr_decoder.sv
hdl/instdec_stage.sv
sim/tb_instdec_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_instdec_stage
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && false)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
